// File: poly_eval_top.f
design/poly_pkg.sv
design/coef_mem_pkg.sv
design/coef_bus_if.sv
design/coef_store.sv
design/command_decoder.sv
design/coef_loader.sv
design/horner_eval.sv
design/firing_controller.sv
design/poly_eval_top.sv
dv/poly_eval_tb.sv

// File: Makefile
# Verilator build and run for the polynomial evaluation actor

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		-f poly_eval_top.f --top-module poly_eval_tb -o poly_eval_sim
	./obj_dir/poly_eval_sim 2>&1 | tee $(LOG)
	@grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/poly_eval_tb.sv
// --------------------
// polynomial actor testbench
// FIFO models, parent firing sequence, reference
// coefficient tables and output assertions
// --------------------
`timescale 1ns/1ps
module poly_eval_tb
    import poly_pkg::*;
();

    localparam int MAX_CYCLES = 20000;

    logic       clk;
    logic       rst;
    logic       start_fire;
    fire_mode_t fire_mode;
    word_t      command_in    = '0;
    logic       command_empty = 1'b1;
    word_t      data_in       = '0;
    logic       data_empty    = 1'b1;
    logic       result_full   = 1'b0;
    logic       rd_command;
    logic       rd_data;
    logic       done_fire;
    word_t      result;
    word_t      status;
    logic       wr_result;

    // FIFO contents and expected output pairs
    word_t cmd_q[$];
    word_t data_q[$];
    word_t exp_res_q[$];
    word_t exp_sta_q[$];
    logic  exp_valid  = 1'b0;
    word_t exp_result = '0;
    word_t exp_status = '0;

    // reference coefficient tables
    word_t ref_coef [8][16];
    int    ref_cnt [8];

    logic [31:0] rng    = 32'd69579;
    int          cycles = 0;

    poly_eval_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .command_in    (command_in),
        .command_empty (command_empty),
        .rd_command    (rd_command),
        .data_in       (data_in),
        .data_empty    (data_empty),
        .rd_data       (rd_data),
        .start_fire    (start_fire),
        .fire_mode     (fire_mode),
        .done_fire     (done_fire),
        .result        (result),
        .status        (status),
        .result_full   (result_full),
        .wr_result     (wr_result)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    // Horner's rule with the highest degree stored first
    function automatic word_t horner_ref(input int slot, input word_t x);
        word_t acc;
        acc = '0;
        for (int i = 0; i < ref_cnt[slot]; i++)
        begin
            acc = acc * x + ref_coef[slot][i];
        end
        return acc;
    endfunction

    function automatic word_t make_cmd(input logic [7:0] code, input poly_id_t slot,
                                       input count_t n);
        return {code, slot, n};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // --------------------
    // FIFO models pop at the edge and show new levels 2 ns later
    always @(posedge clk)
    begin
        if (rd_command && cmd_q.size() > 0)
            void'(cmd_q.pop_front());
        if (rd_data && data_q.size() > 0)
            void'(data_q.pop_front());
        if (wr_result && exp_res_q.size() > 0)
        begin
            void'(exp_res_q.pop_front());
            void'(exp_sta_q.pop_front());
        end
        #2;
        command_empty = (cmd_q.size() == 0);
        command_in    = command_empty ? '0 : cmd_q[0];
        data_empty    = (data_q.size() == 0);
        data_in       = data_empty ? '0 : data_q[0];
        exp_valid     = (exp_res_q.size() > 0);
        exp_result    = exp_valid ? exp_res_q[0] : '0;
        exp_status    = exp_valid ? exp_sta_q[0] : '0;
        // roughly one stall in four
        result_full   = (next_rand() % 4) == 0;
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES)
            abort_run("timeout: the run did not finish within the cycle limit");
    end

    // --------------------
    // output checks
    result_matches: assert property (@(posedge clk) disable iff (!rst)
        wr_result |-> exp_valid && result == exp_result && status == exp_status)
    else
    begin
        abort_run($sformatf("ERROR at %0t: result %h status %h, expected %h %h",
            $time, $sampled(result), $sampled(status), $sampled(exp_result),
            $sampled(exp_status)));
    end

    no_write_when_full: assert property (@(posedge clk) disable iff (!rst)
        wr_result |-> !result_full)
    else
    begin
        abort_run("result written while the result FIFO was full");
    end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst)
        !(rd_data && data_empty) && !(rd_command && command_empty))
    else
    begin
        abort_run("an empty input FIFO was popped");
    end

    no_lost_output: assert property (@(posedge clk) disable iff (!rst)
        done_fire |-> !exp_valid)
    else
    begin
        abort_run("done_fire came while expected outputs were still missing");
    end

    // --------------------
    // parent and instruction sequences
    task automatic fire(input fire_mode_t mode);
        @(posedge clk);
        #2;
        fire_mode  = mode;
        start_fire = 1'b1;
        @(posedge clk);
        #2;
        start_fire = 1'b0;
        @(posedge clk);
        #1;
        while (!done_fire)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_data_left(input int left, input string what);
        data_left: assert (data_q.size() == left)
        else
        begin
            abort_run($sformatf("ERROR at %0t: %s left %0d data words, expected %0d",
                $time, what, data_q.size(), left));
        end
        data_q.delete();
    endtask

    task automatic issue_command(input word_t cmd);
        @(negedge clk);
        cmd_q.push_back(cmd);
        fire(SETUP);
        cmd_taken: assert (cmd_q.size() == 0)
        else
        begin
            abort_run("setup firing did not pop the command word");
        end
    endtask

    task automatic load_coefs(input poly_id_t slot, input count_t n);
        logic  bad;
        word_t c;
        int    i;
        bad = (n == 0) || (n > 16);
        issue_command(make_cmd(STP, slot, n));
        @(negedge clk);
        if (bad)
        begin
            exp_res_q.push_back('0);
            exp_sta_q.push_back(STATUS_BAD_COUNT);
        end
        else
        begin
            for (i = 0; i < n; i++)
            begin
                c = word_t'(next_rand());
                data_q.push_back(c);
                ref_coef[slot][i] = c;
            end
            ref_cnt[slot] = n;
            exp_res_q.push_back(word_t'(n));
            exp_sta_q.push_back(STATUS_OK);
        end
        // guard words that must stay unread
        data_q.push_back(16'h5a5a);
        data_q.push_back(16'ha5a5);
        fire(INSTR);
        check_data_left(2, "STP");
    endtask

    task automatic evaluate_slot(input instr_t op, input poly_id_t slot, input count_t b);
        int    pts;
        int    i;
        word_t x;
        pts = (op == EVB) ? int'(b) : 1;
        issue_command(make_cmd(op, slot, (op == EVB) ? b : count_t'(0)));
        @(negedge clk);
        for (i = 0; i < pts; i++)
        begin
            x = word_t'(next_rand());
            data_q.push_back(x);
            exp_res_q.push_back(ref_cnt[slot] == 0 ? word_t'(0) : horner_ref(slot, x));
            exp_sta_q.push_back(ref_cnt[slot] == 0 ? STATUS_EMPTY_POLY : STATUS_OK);
        end
        // one point beyond the block
        data_q.push_back(16'h0bad);
        fire(INSTR);
        check_data_left(1, "evaluation");
    endtask

    task automatic clear_slots();
        int s;
        issue_command(make_cmd(RST, 3'd0, 5'd0));
        fire(INSTR);
        for (s = 0; s < 8; s++)
        begin
            ref_cnt[s] = 0;
        end
    endtask

    task automatic send_unknown();
        issue_command(make_cmd(8'h07, 3'd2, 5'd4));
        @(negedge clk);
        data_q.push_back(16'h1234);
        data_q.push_back(16'h4321);
        fire(INSTR);
        check_data_left(2, "unknown instruction");
    endtask

    initial
    begin
        int s;
        rst        = 1'b0;
        start_fire = 1'b0;
        fire_mode  = SETUP;
        for (s = 0; s < 8; s++)
        begin
            ref_cnt[s] = 0;
        end
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b1;

        // loads of random length and then bad counts
        for (s = 0; s < 6; s++)
        begin
            load_coefs(poly_id_t'(s), count_t'(next_rand() % 16 + 1));
        end
        load_coefs(3'd6, 5'd16);
        load_coefs(3'd7, 5'd0);
        load_coefs(3'd7, 5'd17);

        // slot 7 is still empty here
        for (s = 0; s < 8; s++)
        begin
            evaluate_slot(EVP, poly_id_t'(s), 5'd0);
        end
        evaluate_slot(EVB, 3'd1, 5'd5);
        evaluate_slot(EVB, 3'd6, 5'd3);
        evaluate_slot(EVB, 3'd2, 5'd0);

        load_coefs(3'd0, 5'd1);
        evaluate_slot(EVP, 3'd0, 5'd0);
        send_unknown();

        clear_slots();
        for (s = 0; s < 8; s++)
        begin
            evaluate_slot(EVP, poly_id_t'(s), 5'd0);
        end
        evaluate_slot(EVB, 3'd4, 5'd2);

        repeat (4) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: design/poly_eval_top.sv
// --------------------
// polynomial evaluation actor
// FIFO-facing top level around controller, decoder,
// loader, evaluator and coefficient store
// --------------------
`timescale 1ns/1ps
module poly_eval_top
    import poly_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  word_t      command_in,
    input  logic       command_empty,
    output logic       rd_command,
    input  word_t      data_in,
    input  logic       data_empty,
    output logic       rd_data,
    input  logic       start_fire,
    input  fire_mode_t fire_mode,
    output logic       done_fire,
    output word_t      result,
    output word_t      status,
    input  logic       result_full,
    output logic       wr_result
);

    instr_t   instr;
    poly_id_t poly_id;
    count_t   count;
    logic     start_decode;
    logic     decode_done;
    logic     start_load;
    logic     load_done;
    logic     start_eval;
    logic     eval_done;
    logic     ld_rd_data;
    logic     ev_rd_data;
    logic     ld_wr;
    logic     ev_wr;
    word_t    ld_result;
    word_t    ld_status;
    word_t    ev_result;
    word_t    ev_status;
    logic     use_loader;

    coef_bus_if ld_bus ();
    coef_bus_if ev_bus ();

    // engines never pop data in the same firing
    assign rd_data    = ld_rd_data | ev_rd_data;
    assign use_loader = (instr == STP) || (instr == RST);
    assign result     = use_loader ? ld_result : ev_result;
    assign status     = use_loader ? ld_status : ev_status;
    assign wr_result  = use_loader ? ld_wr : ev_wr;

    firing_controller u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .start_fire   (start_fire),
        .fire_mode    (fire_mode),
        .instr        (instr),
        .done_fire    (done_fire),
        .start_decode (start_decode),
        .decode_done  (decode_done),
        .start_load   (start_load),
        .load_done    (load_done),
        .start_eval   (start_eval),
        .eval_done    (eval_done)
    );

    command_decoder u_dec (
        .clk           (clk),
        .rst           (rst),
        .start         (start_decode),
        .command_in    (command_in),
        .command_empty (command_empty),
        .rd_command    (rd_command),
        .done          (decode_done),
        .instr         (instr),
        .poly_id       (poly_id),
        .count         (count)
    );

    coef_loader u_load (
        .clk         (clk),
        .rst         (rst),
        .start       (start_load),
        .instr       (instr),
        .poly_id     (poly_id),
        .count       (count),
        .data_in     (data_in),
        .data_empty  (data_empty),
        .rd_data     (ld_rd_data),
        .result_full (result_full),
        .result      (ld_result),
        .status      (ld_status),
        .wr_result   (ld_wr),
        .done        (load_done),
        .bus         (ld_bus)
    );

    horner_eval u_eval (
        .clk         (clk),
        .rst         (rst),
        .start       (start_eval),
        .instr       (instr),
        .poly_id     (poly_id),
        .count       (count),
        .data_in     (data_in),
        .data_empty  (data_empty),
        .rd_data     (ev_rd_data),
        .result_full (result_full),
        .result      (ev_result),
        .status      (ev_status),
        .wr_result   (ev_wr),
        .done        (eval_done),
        .bus         (ev_bus)
    );

    coef_store u_store (
        .clk       (clk),
        .rst       (rst),
        .loader    (ld_bus),
        .evaluator (ev_bus)
    );

endmodule

// File: design/firing_controller.sv
// --------------------
// firing controller
// setup mode runs the decoder, instruction mode runs
// the engine for the decoded instruction, then done
// --------------------
`timescale 1ns/1ps
module firing_controller
    import poly_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start_fire,
    input  fire_mode_t fire_mode,
    input  instr_t     instr,
    output logic       done_fire,
    output logic       start_decode,
    input  logic       decode_done,
    output logic       start_load,
    input  logic       load_done,
    output logic       start_eval,
    input  logic       eval_done
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_DECODE,
        S_LOAD,
        S_EVAL,
        S_FINISH
    } fc_state_t;

    fc_state_t state;
    fc_state_t next_state;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            state <= S_IDLE;
        else
            state <= next_state;
    end

    // --------------------
    // next state
    always_comb
    begin
        next_state = state;
        case (state)
            S_IDLE:
            begin
                if (start_fire)
                begin
                    if (fire_mode == SETUP)
                    begin
                        next_state = S_DECODE;
                    end
                    else if (fire_mode == INSTR)
                    begin
                        case (instr)
                            STP, RST: next_state = S_LOAD;
                            EVP, EVB: next_state = S_EVAL;
                            // unknown instruction, nothing to run
                            default:  next_state = S_FINISH;
                        endcase
                    end
                    else
                    begin
                        next_state = S_FINISH;
                    end
                end
            end
            S_DECODE:
            begin
                if (decode_done)
                    next_state = S_FINISH;
            end
            S_LOAD:
            begin
                if (load_done)
                    next_state = S_FINISH;
            end
            S_EVAL:
            begin
                if (eval_done)
                    next_state = S_FINISH;
            end
            default:
            begin
                next_state = S_IDLE;
            end
        endcase
    end

    // one-cycle pulses on entry and at the end
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            start_decode <= 1'b0;
            start_load   <= 1'b0;
            start_eval   <= 1'b0;
            done_fire    <= 1'b0;
        end
        else
        begin
            start_decode <= (state == S_IDLE) && (next_state == S_DECODE);
            start_load   <= (state == S_IDLE) && (next_state == S_LOAD);
            start_eval   <= (state == S_IDLE) && (next_state == S_EVAL);
            done_fire    <= (state == S_FINISH);
        end
    end

endmodule

// File: design/horner_eval.sv
// --------------------
// Horner evaluator
// EVP evaluates one point, EVB a block of b points;
// coefficients are folded in stored order, highest degree first
// --------------------
`timescale 1ns/1ps
module horner_eval
    import poly_pkg::*, coef_mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  instr_t   instr,
    input  poly_id_t poly_id,
    input  count_t   count,
    input  word_t    data_in,
    input  logic     data_empty,
    output logic     rd_data,
    input  logic     result_full,
    output word_t    result,
    output word_t    status,
    output logic     wr_result,
    output logic     done,
    coef_bus_if.peer bus
);

    typedef enum logic [2:0] {
        E_IDLE,
        E_CNT,
        E_CNT_WAIT,
        E_X,
        E_RD,
        E_ACC,
        E_OUT
    } ev_state_t;

    ev_state_t state;
    coef_idx_t idx;
    count_t    n_coef;
    count_t    pts_left;
    word_t     x_q;
    word_t     acc;

    assign rd_data   = (state == E_X) && !data_empty;
    assign wr_result = (state == E_OUT) && !result_full;
    assign result    = acc;

    // read-only peer
    assign bus.req         = (state == E_CNT) || (state == E_RD);
    assign bus.we          = 1'b0;
    assign bus.addr        = {poly_id, idx};
    assign bus.wdata       = '0;
    assign bus.count_we    = 1'b0;
    assign bus.count_wdata = '0;
    assign bus.clear_all   = 1'b0;

    // --------------------
    // sequencing
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state    <= E_IDLE;
            idx      <= '0;
            n_coef   <= '0;
            pts_left <= '0;
            done     <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                E_IDLE:
                begin
                    if (start)
                    begin
                        idx      <= '0;
                        pts_left <= (instr == EVB) ? count : count_t'(1);
                        // empty block finishes at once
                        if (instr == EVB && count == '0)
                            done <= 1'b1;
                        else
                            state <= E_CNT;
                    end
                end
                E_CNT:
                begin
                    if (bus.gnt)
                        state <= E_CNT_WAIT;
                end
                E_CNT_WAIT:
                begin
                    n_coef <= bus.count;
                    state  <= E_X;
                end
                E_X:
                begin
                    if (!data_empty)
                    begin
                        idx   <= '0;
                        state <= (n_coef == '0) ? E_OUT : E_RD;
                    end
                end
                E_RD:
                begin
                    if (bus.gnt)
                        state <= E_ACC;
                end
                E_ACC:
                begin
                    idx   <= idx + 1'b1;
                    state <= (count_t'(idx) == n_coef - 5'd1) ? E_OUT : E_RD;
                end
                E_OUT:
                begin
                    if (!result_full)
                    begin
                        pts_left <= pts_left - 5'd1;
                        if (pts_left == 5'd1)
                        begin
                            state <= E_IDLE;
                            done  <= 1'b1;
                        end
                        else
                        begin
                            state <= E_X;
                        end
                    end
                end
                default:
                begin
                    state <= E_IDLE;
                end
            endcase
        end
    end

    // --------------------
    // datapath, wraps modulo 2^16
    always_ff @(posedge clk)
    begin
        if (rd_data)
        begin
            x_q    <= data_in;
            acc    <= '0;
            status <= (n_coef == '0) ? STATUS_EMPTY_POLY : STATUS_OK;
        end
        if (state == E_ACC)
        begin
            acc <= acc * x_q + bus.rdata;
        end
    end

endmodule

// File: design/coef_loader.sv
// --------------------
// coefficient loader
// STP streams N data words into a slot and sets its count,
// RST clears every count in the store
// --------------------
`timescale 1ns/1ps
module coef_loader
    import poly_pkg::*, coef_mem_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  instr_t   instr,
    input  poly_id_t poly_id,
    input  count_t   count,
    input  word_t    data_in,
    input  logic     data_empty,
    output logic     rd_data,
    input  logic     result_full,
    output word_t    result,
    output word_t    status,
    output logic     wr_result,
    output logic     done,
    coef_bus_if.peer bus
);

    typedef enum logic [2:0] {
        L_IDLE,
        L_READ,
        L_WRITE,
        L_COUNT,
        L_OUT,
        L_CLEAR
    } ld_state_t;

    ld_state_t state;
    coef_idx_t idx;
    word_t     coef_q;
    logic      bad_count;

    assign bad_count = (count == '0) || (count > MAX_COEFS);

    assign rd_data   = (state == L_READ) && !data_empty;
    assign wr_result = (state == L_OUT) && !result_full;

    assign bus.req         = (state == L_WRITE) || (state == L_COUNT);
    assign bus.we          = (state == L_WRITE);
    assign bus.addr        = {poly_id, idx};
    assign bus.wdata       = coef_q;
    assign bus.count_we    = (state == L_COUNT);
    assign bus.count_wdata = count;
    assign bus.clear_all   = (state == L_CLEAR);

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            state <= L_IDLE;
            idx   <= '0;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                L_IDLE:
                begin
                    if (start)
                    begin
                        idx <= '0;
                        if (instr == RST)
                            state <= L_CLEAR;
                        else if (bad_count)
                            state <= L_OUT;
                        else
                            state <= L_READ;
                    end
                end
                L_READ:
                begin
                    if (!data_empty)
                        state <= L_WRITE;
                end
                L_WRITE:
                begin
                    if (bus.gnt)
                    begin
                        idx <= idx + 1'b1;
                        // count write follows the last coefficient
                        if (count_t'(idx) == count - 5'd1)
                            state <= L_COUNT;
                        else
                            state <= L_READ;
                    end
                end
                L_COUNT:
                begin
                    if (bus.gnt)
                        state <= L_OUT;
                end
                L_OUT:
                begin
                    if (!result_full)
                    begin
                        state <= L_IDLE;
                        done  <= 1'b1;
                    end
                end
                L_CLEAR:
                begin
                    state <= L_IDLE;
                    done  <= 1'b1;
                end
                default:
                begin
                    state <= L_IDLE;
                end
            endcase
        end
    end

    // output pair is fixed at start
    always_ff @(posedge clk)
    begin
        if (rd_data)
        begin
            coef_q <= data_in;
        end
        if (state == L_IDLE && start)
        begin
            result <= bad_count ? '0 : word_t'(count);
            status <= bad_count ? STATUS_BAD_COUNT : STATUS_OK;
        end
    end

endmodule

// File: design/command_decoder.sv
// --------------------
// command decoder
// pops one command word and keeps its fields
// --------------------
`timescale 1ns/1ps
module command_decoder
    import poly_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     start,
    input  word_t    command_in,
    input  logic     command_empty,
    output logic     rd_command,
    output logic     done,
    output instr_t   instr,
    output poly_id_t poly_id,
    output count_t   count
);

    logic busy;

    // show-ahead FIFO, the word is valid while not empty
    assign rd_command = busy && !command_empty;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            busy    <= 1'b0;
            done    <= 1'b0;
            instr   <= STP;
            poly_id <= '0;
            count   <= '0;
        end
        else
        begin
            done <= rd_command;
            if (start)
            begin
                busy <= 1'b1;
            end
            else if (rd_command)
            begin
                busy <= 1'b0;
            end
            if (rd_command)
            begin
                instr   <= instr_t'(command_in[INSTR_LSB +: $bits(instr_t)]);
                poly_id <= command_in[ID_LSB +: $bits(poly_id_t)];
                count   <= command_in[ID_LSB-1:0];
            end
        end
    end

endmodule

// File: design/coef_store.sv
// --------------------
// coefficient store
// 128x16 synchronous RAM with a per-slot count table,
// shared by loader and evaluator, loader has priority
// --------------------
`timescale 1ns/1ps
module coef_store
    import poly_pkg::*, coef_mem_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    coef_bus_if.store loader,
    coef_bus_if.store evaluator
);

    word_t      mem [NUM_POLYS*MAX_COEFS];
    count_t     cnt_tab [NUM_POLYS];
    word_t      rdata_q;
    count_t     count_q;
    logic       use_ld;
    coef_addr_t sel_addr;
    poly_id_t   sel_slot;
    logic       sel_we;
    word_t      sel_wdata;
    logic       sel_cnt_we;
    count_t     sel_cnt_wdata;
    logic       clear;

    // --------------------
    // fixed-priority arbiter
    assign use_ld        = loader.req;
    assign loader.gnt    = loader.req;
    assign evaluator.gnt = evaluator.req && !loader.req;

    assign sel_addr      = use_ld ? loader.addr : evaluator.addr;
    assign sel_slot      = sel_addr[COEF_ADDR_W-1:IDX_W];
    assign sel_we        = use_ld ? loader.we : (evaluator.req && evaluator.we);
    assign sel_wdata     = use_ld ? loader.wdata : evaluator.wdata;
    assign sel_cnt_we    = use_ld ? loader.count_we
                                  : (evaluator.req && evaluator.count_we);
    assign sel_cnt_wdata = use_ld ? loader.count_wdata : evaluator.count_wdata;
    assign clear         = loader.clear_all || evaluator.clear_all;

    // --------------------
    // coefficient RAM, read data a cycle later
    always_ff @(posedge clk)
    begin
        if (sel_we)
        begin
            mem[sel_addr] <= sel_wdata;
        end
        rdata_q <= mem[sel_addr];
    end

    // count table, zero means empty slot
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            for (int i = 0; i < NUM_POLYS; i++)
            begin
                cnt_tab[i] <= '0;
            end
            count_q <= '0;
        end
        else
        begin
            if (clear)
            begin
                for (int i = 0; i < NUM_POLYS; i++)
                begin
                    cnt_tab[i] <= '0;
                end
            end
            else if (sel_cnt_we)
            begin
                cnt_tab[sel_slot] <= sel_cnt_wdata;
            end
            count_q <= cnt_tab[sel_slot];
        end
    end

    assign loader.rdata    = rdata_q;
    assign evaluator.rdata = rdata_q;
    assign loader.count    = count_q;
    assign evaluator.count = count_q;

endmodule

// File: design/coef_bus_if.sv
// --------------------
// coefficient memory port
// one requester's view of the shared store
// --------------------
`timescale 1ns/1ps
interface coef_bus_if
    import poly_pkg::*, coef_mem_pkg::*;
    ();

    logic       req;
    logic       we;
    coef_addr_t addr;
    word_t      wdata;
    word_t      rdata;
    logic       count_we;
    count_t     count_wdata;
    count_t     count;
    logic       clear_all;
    logic       gnt;

    modport peer (
        output req, we, addr, wdata, count_we, count_wdata, clear_all,
        input  gnt, rdata, count
    );

    modport store (
        input  req, we, addr, wdata, count_we, count_wdata, clear_all,
        output gnt, rdata, count
    );

endinterface

// File: design/coef_mem_pkg.sv
// --------------------
// coefficient memory geometry
// slot count, depth per slot and address types
// --------------------
package coef_mem_pkg;

    localparam int NUM_POLYS = 8;
    localparam int MAX_COEFS = 16;

    localparam int IDX_W       = 4;
    localparam int COEF_ADDR_W = 7;

    // address is slot * MAX_COEFS + index
    typedef logic [COEF_ADDR_W-1:0] coef_addr_t;
    typedef logic [IDX_W-1:0]       coef_idx_t;

endpackage

// File: design/poly_pkg.sv
// --------------------
// polynomial actor definitions
// command word format, instruction and status
// codes, and the word types shared by all blocks
// --------------------
package poly_pkg;

    // data, coefficient, result and status words
    typedef logic [15:0] word_t;

    // instruction field, other encodings are unknown
    typedef enum logic [7:0] {
        STP = 8'd0,
        EVP = 8'd1,
        EVB = 8'd2,
        RST = 8'd3
    } instr_t;

    typedef logic [2:0] poly_id_t;
    // coefficient count N, or block length b
    typedef logic [4:0] count_t;

    typedef enum logic [1:0] {
        SETUP = 2'd0,
        INSTR = 2'd1
    } fire_mode_t;

    // command layout: instr 15..8, slot 7..5, count 4..0
    localparam int INSTR_LSB = 8;
    localparam int ID_LSB    = 5;

    localparam word_t STATUS_OK         = 16'd0;
    localparam word_t STATUS_BAD_COUNT  = 16'd1;
    localparam word_t STATUS_EMPTY_POLY = 16'd2;

endpackage
